// ==== Makefile ====
# Verilator flow for the probability multiplier

VERILATOR ?= verilator
TOP       ?= prob_multiplier_tb
SEED      ?= 32917
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert

SOURCES := $(wildcard design/*.sv testbench/*.sv testbench/*.svh)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# the simulator exits non-zero on $fatal, so make fails with it
sim: $(BINARY)
	./$(BINARY) +verilator+seed+$(SEED)

clean:
	rm -rf $(BUILD_DIR)

// ==== design/fixed_fmt_pkg.sv ====
`default_nettype none

package fixed_fmt_pkg;

    // unsigned Q1.20, bit 20 weighs 1.0
    typedef logic [20:0] fixed_t;

    // full Q2.40 product of two fixed_t values
    typedef logic [41:0] product_t;

    localparam int FRAC_BITS = 20;

    localparam fixed_t FIXED_ONE = 21'h10_0000;

    // stage 1 output, both operands in fixed point
    typedef struct packed {
        logic   valid;
        fixed_t a;
        fixed_t b;
        logic   out_of_range;
    } fixed_pair_t;

    // stage 2 output, truncated product
    typedef struct packed {
        logic   valid;
        fixed_t product;
        logic   out_of_range;
    } fixed_result_t;

endpackage

`default_nettype wire

// ==== design/fixed_multiplier.sv ====
`default_nettype none

module fixed_multiplier (
    input  logic                          clk,
    input  logic                          reset,
    input  fixed_fmt_pkg::fixed_pair_t    pair,
    output fixed_fmt_pkg::fixed_result_t  result
);

    fixed_fmt_pkg::product_t full_product;

    assign full_product = pair.a * pair.b;

    always_ff @(posedge clk) begin
        // Q2.40 back to Q1.20 by dropping the low fraction bits
        result.product <= full_product[fixed_fmt_pkg::FRAC_BITS +:
                                       $bits(fixed_fmt_pkg::fixed_t)];
        if (reset) begin
            result.valid        <= 1'b0;
            result.out_of_range <= 1'b0;
        end else begin
            result.valid        <= pair.valid;
            result.out_of_range <= pair.out_of_range;
        end
    end

    // operands are at most 1.0, so the product is too
    a_product_bounded: assert property (@(posedge clk) disable iff (reset)
        result.valid |-> (result.product <= fixed_fmt_pkg::FIXED_ONE));

endmodule

`default_nettype wire

// ==== design/fixed_to_float.sv ====
`default_nettype none

module fixed_to_float (
    input  logic                          clk,
    input  logic                          reset,
    input  fixed_fmt_pkg::fixed_result_t  result,
    output logic                          out_valid,
    output float_fmt_pkg::float_word_t    out_result,
    output fixed_fmt_pkg::fixed_t         out_fixed,
    output logic                          out_range
);

    localparam int PAD_BITS = 32 - $bits(fixed_fmt_pkg::fixed_t);

    logic [31:0] padded;
    logic [4:0]  lead_index;
    logic        lead_found;

    // bit 20 of the fixed value lands on bit 31
    assign padded = {result.product, PAD_BITS'(0)};

    leading_one_encoder leading_one_encoder_i (
        .value (padded),
        .index (lead_index),
        .found (lead_found)
    );

    fixed_fmt_pkg::fixed_t      normalized;
    float_fmt_pkg::float_exp_t  exponent;
    float_fmt_pkg::float_mant_t mantissa;
    float_fmt_pkg::float_word_t word;

    always_comb begin
        normalized = result.product << lead_index;
        exponent   = float_fmt_pkg::EXP_BIAS - float_fmt_pkg::float_exp_t'(lead_index);
        // hidden one dropped, rest left aligned
        mantissa   = {normalized[fixed_fmt_pkg::FRAC_BITS-1:0],
                      ($bits(float_fmt_pkg::float_mant_t) - fixed_fmt_pkg::FRAC_BITS)'(0)};
        if (lead_found) begin
            word = {1'b0, exponent, mantissa};
        end else begin
            word = '0;
        end
    end

    always_ff @(posedge clk) begin
        out_result <= word;
        out_fixed  <= result.product;
        if (reset) begin
            out_valid <= 1'b0;
            out_range <= 1'b0;
        end else begin
            out_valid <= result.valid;
            out_range <= result.out_of_range;
        end
    end

    // the encoder misses a one only when the product is zero
    a_zero_when_not_found: assert property (@(posedge clk) disable iff (reset)
        (result.valid && !lead_found) |-> (result.product == '0));

endmodule

`default_nettype wire

// ==== design/float_fmt_pkg.sv ====
`default_nettype none

package float_fmt_pkg;

    // one IEEE-754 single-precision word
    typedef logic [31:0] float_word_t;

    // biased exponent field
    typedef logic [7:0] float_exp_t;

    // stored significand, hidden one not included
    typedef logic [22:0] float_mant_t;

    // exponent of 1.0
    localparam float_exp_t EXP_BIAS = 8'd127;

endpackage

`default_nettype wire

// ==== design/float_to_fixed.sv ====
`default_nettype none

module float_to_fixed (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        in_valid,
    input  float_fmt_pkg::float_word_t  in_a,
    input  float_fmt_pkg::float_word_t  in_b,
    output fixed_fmt_pkg::fixed_pair_t  pair
);

    typedef struct packed {
        logic                   flag;
        fixed_fmt_pkg::fixed_t  value;
    } operand_t;

    // negative, above 1.0, nan and inf all saturate to 1.0
    function automatic operand_t convert_operand(input float_fmt_pkg::float_word_t word);
        logic                       sign;
        float_fmt_pkg::float_exp_t  exponent;
        float_fmt_pkg::float_mant_t mantissa;
        float_fmt_pkg::float_exp_t  shift;
        operand_t                   op;
        sign     = word[31];
        exponent = word[30:23];
        mantissa = word[22:0];
        shift    = float_fmt_pkg::EXP_BIAS - exponent;
        if (sign || (exponent > float_fmt_pkg::EXP_BIAS) ||
            ((exponent == float_fmt_pkg::EXP_BIAS) && (mantissa != '0))) begin
            op.flag  = 1'b1;
            op.value = fixed_fmt_pkg::FIXED_ONE;
        end else begin
            op.flag = 1'b0;
            // shifts past the hidden one leave nothing, exponent 0 included
            if (shift >= float_fmt_pkg::float_exp_t'($bits(fixed_fmt_pkg::fixed_t))) begin
                op.value = '0;
            end else begin
                op.value = {1'b1, mantissa[$bits(mantissa)-1 -: fixed_fmt_pkg::FRAC_BITS]}
                           >> shift;
            end
        end
        return op;
    endfunction

    operand_t op_a;
    operand_t op_b;

    assign op_a = convert_operand(in_a);
    assign op_b = convert_operand(in_b);

    always_ff @(posedge clk) begin
        pair.a <= op_a.value;
        pair.b <= op_b.value;
        if (reset) begin
            pair.valid        <= 1'b0;
            pair.out_of_range <= 1'b0;
        end else begin
            pair.valid        <= in_valid;
            pair.out_of_range <= in_valid & (op_a.flag | op_b.flag);
        end
    end

    // a flagged item must carry at least one saturated operand
    a_range_saturates: assert property (@(posedge clk) disable iff (reset)
        pair.out_of_range |->
            (pair.a == fixed_fmt_pkg::FIXED_ONE) || (pair.b == fixed_fmt_pkg::FIXED_ONE));

endmodule

`default_nettype wire

// ==== design/leading_one_encoder.sv ====
`default_nettype none

module leading_one_encoder (
    input  logic [31:0] value,
    output logic [4:0]  index,
    output logic        found
);

    // 4-input priority encoder, bit 3 wins, returns {hit, position}
    function automatic logic [2:0] encode4(input logic [3:0] nibble);
        logic [1:0] pos;
        if (nibble[3]) begin
            pos = 2'd0;
        end else if (nibble[2]) begin
            pos = 2'd1;
        end else if (nibble[1]) begin
            pos = 2'd2;
        end else begin
            pos = 2'd3;
        end
        return {|nibble, pos};
    endfunction

    // group 0 holds the top four bits
    logic [0:7] group_hit;
    logic [1:0] group_pos [8];

    for (genvar g = 0; g < 8; g++) begin : g_group
        assign {group_hit[g], group_pos[g]} = encode4(value[31 - 4*g -: 4]);
    end

    // second level over the group hits, two halves of four
    logic [1:0] half_hit;
    logic [1:0] half_pos [2];

    for (genvar h = 0; h < 2; h++) begin : g_half
        assign {half_hit[h], half_pos[h]} = encode4(group_hit[4*h +: 4]);
    end

    logic [2:0] group_idx;
    logic [1:0] low_pos;

    assign found     = |half_hit;
    assign group_idx = half_hit[0] ? {1'b0, half_pos[0]} : {1'b1, half_pos[1]};

    always_comb begin
        case (group_idx)
            3'd0: low_pos = group_pos[0];
            3'd1: low_pos = group_pos[1];
            3'd2: low_pos = group_pos[2];
            3'd3: low_pos = group_pos[3];
            3'd4: low_pos = group_pos[4];
            3'd5: low_pos = group_pos[5];
            3'd6: low_pos = group_pos[6];
            3'd7: low_pos = group_pos[7];
            default: low_pos = 2'd0;
        endcase
        index = {group_idx, low_pos};
    end

endmodule

`default_nettype wire

// ==== design/prob_multiplier.sv ====
`default_nettype none

module prob_multiplier (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        in_valid,
    input  float_fmt_pkg::float_word_t  in_a,
    input  float_fmt_pkg::float_word_t  in_b,
    output logic                        out_valid,
    output float_fmt_pkg::float_word_t  out_result,
    output fixed_fmt_pkg::fixed_t       out_fixed,
    output logic                        out_range
);

    fixed_fmt_pkg::fixed_pair_t   pair;
    fixed_fmt_pkg::fixed_result_t result;

    // stage 1, float to Q1.20
    float_to_fixed float_to_fixed_i (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .in_a     (in_a),
        .in_b     (in_b),
        .pair     (pair)
    );

    // stage 2, fixed point multiply
    fixed_multiplier fixed_multiplier_i (
        .clk    (clk),
        .reset  (reset),
        .pair   (pair),
        .result (result)
    );

    // stage 3, back to single precision
    fixed_to_float fixed_to_float_i (
        .clk        (clk),
        .reset      (reset),
        .result     (result),
        .out_valid  (out_valid),
        .out_result (out_result),
        .out_fixed  (out_fixed),
        .out_range  (out_range)
    );

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+testbench
design/float_fmt_pkg.sv
design/fixed_fmt_pkg.sv
design/leading_one_encoder.sv
design/float_to_fixed.sv
design/fixed_multiplier.sv
design/fixed_to_float.sv
design/prob_multiplier.sv
testbench/prob_multiplier_tb.sv

// ==== testbench/prob_model.svh ====
`ifndef PROB_MODEL_SVH
`define PROB_MODEL_SVH

`default_nettype none

// float to Q1.20 as a scaled value, truncated toward zero
// flag marks anything outside [0, 1], which then counts as 1.0
function automatic fixed_fmt_pkg::fixed_t saturate_and_scale(
    input  float_fmt_pkg::float_word_t word,
    output logic                       flag
);
    logic        negative;
    int unsigned exponent;
    int unsigned bias;
    logic [63:0] significand;
    int unsigned scale;
    negative    = word[31];
    exponent    = 32'(word[30:23]);
    bias        = 32'(float_fmt_pkg::EXP_BIAS);
    significand = {40'd0, 1'b1, word[22:0]};
    flag        = 1'b0;
    if (negative || (exponent > bias) || ((exponent == bias) && (word[22:0] != '0))) begin
        flag = 1'b1;
        return fixed_fmt_pkg::FIXED_ONE;
    end
    // zero exponent, no subnormals
    if (exponent == 0) begin
        return '0;
    end
    // value * 2^20 is the 24-bit significand over 2^(bias + 3 - exponent)
    scale = bias + 3 - exponent;
    if (scale >= 24) begin
        return '0;
    end
    return fixed_fmt_pkg::fixed_t'(significand >> scale);
endfunction

function automatic fixed_fmt_pkg::fixed_t truncated_product(
    input fixed_fmt_pkg::fixed_t a,
    input fixed_fmt_pkg::fixed_t b
);
    logic [63:0] full;
    full = 64'(a) * 64'(b);
    // Q2.40 down to Q1.20, low bits dropped
    return fixed_fmt_pkg::fixed_t'(full >> fixed_fmt_pkg::FRAC_BITS);
endfunction

// Q1.20 back to single precision, sign always 0
function automatic float_fmt_pkg::float_word_t normalize_to_float(
    input fixed_fmt_pkg::fixed_t value
);
    int          msb;
    int          exponent;
    logic [31:0] below;
    if (value == '0) begin
        return '0;
    end
    msb = 0;
    for (int i = 0; i < $bits(value); i++) begin
        if (value[i]) begin
            msb = i;
        end
    end
    // value is 1.f times 2^(msb - 20)
    exponent = int'(float_fmt_pkg::EXP_BIAS) - fixed_fmt_pkg::FRAC_BITS + msb;
    below    = 32'(value) - (32'd1 << msb);
    below    = below << (23 - msb);
    return {1'b0, float_fmt_pkg::float_exp_t'(exponent), below[22:0]};
endfunction

`default_nettype wire

`endif

// ==== testbench/prob_multiplier_tb.sv ====
`include "prob_model.svh"

`default_nettype none

module prob_multiplier_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned CLK_HALF       = 4;
    localparam int unsigned RESET_CYCLES   = 16;
    localparam int unsigned LATENCY        = 3;
    localparam int unsigned NUM_RANDOM     = 2000;
    localparam int unsigned NUM_POWERS     = 22;
    localparam int unsigned NUM_SMALL      = 100;
    localparam int unsigned NUM_RANGE      = 100;
    localparam int unsigned NUM_GAPS       = 300;
    localparam int unsigned MAX_GAP        = 4;
    localparam int unsigned SETTLE_CYCLES  = 5;
    localparam int unsigned STIM_CYCLES    = RESET_CYCLES + NUM_RANDOM + NUM_POWERS
        + NUM_SMALL + NUM_RANGE + NUM_GAPS * (MAX_GAP + 1) + 6 * SETTLE_CYCLES + LATENCY + 2;
    localparam int unsigned TIMEOUT_CYCLES = 2 * STIM_CYCLES + 100;

    typedef enum logic [2:0] {
        TEST_RANDOM,
        TEST_POWERS,
        TEST_SMALL,
        TEST_RANGE,
        TEST_GAPS
    } test_id_t;

    typedef struct packed {
        test_id_t                   test;
        logic [31:0]                launch_edge;
        float_fmt_pkg::float_word_t result;
        fixed_fmt_pkg::fixed_t      fixed;
        logic                       range;
    } expected_t;

    logic                       clk;
    logic                       reset;
    logic                       in_valid;
    float_fmt_pkg::float_word_t in_a;
    float_fmt_pkg::float_word_t in_b;
    logic                       out_valid;
    float_fmt_pkg::float_word_t out_result;
    fixed_fmt_pkg::fixed_t      out_fixed;
    logic                       out_range;

    expected_t   expected_q[$];
    int unsigned cycle_count = 0;
    int unsigned items_sent = 0;

    prob_multiplier prob_multiplier_i (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_a       (in_a),
        .in_b       (in_b),
        .out_valid  (out_valid),
        .out_result (out_result),
        .out_fixed  (out_fixed),
        .out_range  (out_range)
    );

    always #(CLK_HALF) clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_with_failure($sformatf("timeout after %0d cycles, %0d results still pending",
                                        cycle_count, expected_q.size()));
        end
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("CHECK FAILED %s expected 0x%0h actual 0x%0h",
                                        name, expected, actual));
        end
    endtask

    function automatic string test_label(input test_id_t id);
        case (id)
            TEST_RANDOM: return "random_operands";
            TEST_POWERS: return "powers_of_two";
            TEST_SMALL:  return "small_operands";
            TEST_RANGE:  return "out_of_range";
            TEST_GAPS:   return "random_gaps";
            default:     return "unknown";
        endcase
    endfunction

    task automatic check_result(input expected_t entry);
        string label;
        label = test_label(entry.test);
        check_value({label, " out_fixed"}, 64'(entry.fixed), 64'(out_fixed));
        check_value({label, " out_result"}, 64'(entry.result), 64'(out_result));
        check_value({label, " out_range"}, 64'(entry.range), 64'(out_range));
        check_value({label, " latency"}, 64'(entry.launch_edge) + 64'(LATENCY),
                    64'(cycle_count));
    endtask

    // outputs are compared on the falling edge
    always @(negedge clk) begin
        if (reset || (items_sent == 0)) begin
            check_value("reset out_valid", 64'd0, 64'(out_valid));
            check_value("reset out_range", 64'd0, 64'(out_range));
        end
        if (out_valid) begin
            if (expected_q.size() == 0) begin
                stop_with_failure("out_valid went high with no item in flight");
            end else begin
                check_result(expected_q.pop_front());
            end
        end
    end

    function automatic float_fmt_pkg::float_word_t random_in_range();
        float_fmt_pkg::float_exp_t  exponent;
        float_fmt_pkg::float_mant_t mantissa;
        exponent = float_fmt_pkg::EXP_BIAS - float_fmt_pkg::float_exp_t'($urandom_range(0, 24));
        mantissa = float_fmt_pkg::float_mant_t'($urandom());
        // at the top exponent only 1.0 itself is in range
        if (exponent == float_fmt_pkg::EXP_BIAS) begin
            mantissa = '0;
        end
        return {1'b0, exponent, mantissa};
    endfunction

    function automatic float_fmt_pkg::float_word_t power_of_two(input int k);
        return {1'b0, float_fmt_pkg::EXP_BIAS - float_fmt_pkg::float_exp_t'(k), 23'd0};
    endfunction

    function automatic float_fmt_pkg::float_word_t special_word(input int idx);
        case (idx)
            0:       return 32'hBF00_0000;
            1:       return 32'hBF80_0000;
            2:       return 32'h3F80_0001;
            3:       return 32'h4000_0000;
            4:       return 32'h7F80_0000;
            5:       return 32'hFF80_0000;
            6:       return 32'h7FC0_0000;
            default: return 32'h8000_0000;
        endcase
    endfunction

    task automatic send_item(input test_id_t test, input float_fmt_pkg::float_word_t a,
                             input float_fmt_pkg::float_word_t b);
        expected_t             entry;
        logic                  flag_a;
        logic                  flag_b;
        fixed_fmt_pkg::fixed_t fixed_a;
        fixed_fmt_pkg::fixed_t fixed_b;
        fixed_a      = saturate_and_scale(a, flag_a);
        fixed_b      = saturate_and_scale(b, flag_b);
        entry.test   = test;
        entry.fixed  = truncated_product(fixed_a, fixed_b);
        entry.result = normalize_to_float(entry.fixed);
        entry.range  = flag_a | flag_b;
        @(posedge clk);
        in_valid <= 1'b1;
        in_a     <= a;
        in_b     <= b;
        entry.launch_edge = cycle_count + 1;
        expected_q.push_back(entry);
        items_sent++;
    endtask

    // junk on the data lines while valid is low
    task automatic idle_cycles(input int unsigned count);
        repeat (count) begin
            @(posedge clk);
            in_valid <= 1'b0;
            in_a     <= $urandom();
            in_b     <= $urandom();
        end
    endtask

    task automatic random_pairs();
        for (int i = 0; i < NUM_RANDOM; i++) begin
            send_item(TEST_RANDOM, random_in_range(), random_in_range());
        end
    endtask

    task automatic power_pairs();
        for (int k = 0; k <= fixed_fmt_pkg::FRAC_BITS; k++) begin
            send_item(TEST_POWERS, power_of_two(k), power_of_two((k * 7) % 21));
        end
        send_item(TEST_POWERS, power_of_two(0), power_of_two(0));
    endtask

    task automatic small_pairs();
        float_fmt_pkg::float_word_t tiny_word;
        for (int i = 0; i < NUM_SMALL; i++) begin
            tiny_word = {1'b0, float_fmt_pkg::float_exp_t'($urandom_range(0, 106)),
                         float_fmt_pkg::float_mant_t'($urandom())};
            if (i % 4 == 0) begin
                tiny_word = '0;
            end
            if (i % 2 == 0) begin
                send_item(TEST_SMALL, tiny_word, random_in_range());
            end else begin
                send_item(TEST_SMALL, random_in_range(), tiny_word);
            end
        end
    endtask

    task automatic range_pairs();
        float_fmt_pkg::float_word_t odd;
        for (int i = 0; i < NUM_RANGE; i++) begin
            odd = special_word(i % 8);
            case (i % 3)
                0:       send_item(TEST_RANGE, odd, random_in_range());
                1:       send_item(TEST_RANGE, random_in_range(), odd);
                default: send_item(TEST_RANGE, odd, special_word((i + 3) % 8));
            endcase
        end
    endtask

    task automatic gapped_pairs();
        for (int i = 0; i < NUM_GAPS; i++) begin
            send_item(TEST_GAPS, random_in_range(), random_in_range());
            idle_cycles($urandom_range(0, MAX_GAP));
        end
    endtask

    initial begin
        clk      = 1'b0;
        reset    = 1'b1;
        in_valid = 1'b0;
        in_a     = '0;
        in_b     = '0;
        void'($urandom(32917));
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        idle_cycles(SETTLE_CYCLES);
        random_pairs();
        idle_cycles(SETTLE_CYCLES);
        power_pairs();
        idle_cycles(SETTLE_CYCLES);
        small_pairs();
        idle_cycles(SETTLE_CYCLES);
        range_pairs();
        idle_cycles(SETTLE_CYCLES);
        gapped_pairs();
        idle_cycles(SETTLE_CYCLES + LATENCY + 2);
        if (expected_q.size() != 0) begin
            stop_with_failure($sformatf("%0d expected results were never produced",
                                        expected_q.size()));
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

`default_nettype wire
